// File: verilog/vdp_timing_pkg.sv
// Dot timing definitions for the bitmap display path
// Four-phase dot state, frame geometry and the dot counter types
// shared by the dot timer and the fetch block

package vdp_timing_pkg;

    // --------------------
    // Dot phases
    // --------------------

    // One dot lasts four CLK21M cycles, phases run in this order
    typedef enum logic [1:0] {
        DS_LATCH = 2'd0,
        DS_OUT   = 2'd1,
        DS_SHIFT = 2'd2,
        DS_ADDR  = 2'd3
    } dot_state_e;

    // --------------------
    // Frame geometry
    // --------------------

    // Dots per line and lines per frame, NTSC
    localparam int H_TOTAL  = 342;
    localparam int V_TOTAL  = 262;

    // Visible area in bitmap modes
    localparam int H_ACTIVE = 256;
    localparam int V_ACTIVE = 212;

    typedef struct packed {
        logic [8:0] x;
        logic [8:0] y;
    } dot_pos_t;

    // Everything the screen mode blocks need from the timer
    typedef struct packed {
        dot_state_e state;
        logic [2:0] eight;
        dot_pos_t   pos;
    } dot_timing_t;

endpackage

// File: verilog/vdp_video_pkg.sv
// Video data definitions for the bitmap display path
// Screen mode, static register set, VRAM access words and the
// pixel word leaving the fetch block

package vdp_video_pkg;

    typedef enum logic [1:0] {
        GRAPHIC4 = 2'd0,
        GRAPHIC5 = 2'd1,
        GRAPHIC6 = 2'd2,
        GRAPHIC7 = 2'd3
    } screen_mode_e;

    // Static register set, no write path
    typedef struct packed {
        screen_mode_e mode;
        logic [6:0]   name_base;
        // Bits 2:0 have no effect, scroll moves in 8-dot steps
        logic [8:0]   h_scroll;
        logic         yjk;
        logic         yae;
    } vdp_regs_t;

    // 128 KB VRAM, bit 16 selects the bank
    typedef logic [16:0] vram_addr_t;

    // --------------------
    // VRAM access words
    // --------------------

    // Host port, four-phase req/ack
    typedef struct packed {
        logic       req;
        logic       write;
        vram_addr_t addr;
        logic [7:0] wdata;
    } host_req_t;

    typedef struct packed {
        logic       ack;
        logic [7:0] rdata;
    } host_rsp_t;

    typedef struct packed {
        logic       valid;
        vram_addr_t addr;
    } fetch_req_t;

    // Byte at the address plus its partner in the other bank
    typedef struct packed {
        logic [7:0] data;
        logic [7:0] data_pair;
    } vram_rd_t;

    // --------------------
    // Pixel output
    // --------------------

    typedef struct packed {
        logic [5:0] r;
        logic [5:0] g;
        logic [5:0] b;
    } rgb_t;

    typedef struct packed {
        logic                     valid;
        vdp_timing_pkg::dot_pos_t pos;
        logic [7:0]               code;
        rgb_t                     rgb;
        logic                     yjk_en;
    } pixel_t;

endpackage

// File: verilog/vdp_dot_timer.sv
// Dot timer
// Rotates the four-phase dot state every clock, counts dots within
// each eight-dot group and runs the X/Y dot counters over the frame

module vdp_dot_timer (
    input  logic                        CLK21M,
    input  logic                        RESET,
    output vdp_timing_pkg::dot_timing_t timing
);

    vdp_timing_pkg::dot_state_e dot_state;
    logic [2:0]                 eight;
    logic [8:0]                 cnt_x;
    logic [8:0]                 cnt_y;
    logic                       line_end;

    // Last dot of the line
    assign line_end = (cnt_x == 9'(vdp_timing_pkg::H_TOTAL - 1));

    always_ff @(posedge CLK21M or posedge RESET) begin
        if (RESET) begin
            dot_state <= vdp_timing_pkg::DS_LATCH;
            eight     <= '0;
            cnt_x     <= '0;
            cnt_y     <= '0;
        end else begin
            // Phase wraps from DS_ADDR back to DS_LATCH
            dot_state <= vdp_timing_pkg::dot_state_e'(dot_state + 2'd1);

            // Counters move once per dot, at its last phase
            if (dot_state == vdp_timing_pkg::DS_ADDR) begin
                if (line_end) begin
                    cnt_x <= '0;
                    // Line length is not a multiple of 8, restart the group
                    eight <= '0;
                    if (cnt_y == 9'(vdp_timing_pkg::V_TOTAL - 1)) begin
                        cnt_y <= '0;
                    end else begin
                        cnt_y <= cnt_y + 9'd1;
                    end
                end else begin
                    cnt_x <= cnt_x + 9'd1;
                    eight <= eight + 3'd1;
                end
            end
        end
    end

    assign timing = '{
        state: dot_state,
        eight: eight,
        pos:   '{x: cnt_x, y: cnt_y}
    };

endmodule

// File: verilog/vdp_vram.sv
// Video RAM, 128 KB as two 64 KB banks
// One-cycle synchronous read that returns the addressed byte and
// the byte at the same offset in the other bank

module vdp_vram (
    input  logic                      CLK21M,
    input  logic                      we,
    input  vdp_video_pkg::vram_addr_t addr,
    input  logic [7:0]                wdata,
    output vdp_video_pkg::vram_rd_t   rd
);

    // Bank 0 holds addresses 00000-0FFFF, bank 1 the rest
    logic [7:0] bank_lo [65536];
    logic [7:0] bank_hi [65536];

    logic [7:0] lo_q;
    logic [7:0] hi_q;
    logic       sel_q;

    always_ff @(posedge CLK21M) begin
        if (we && !addr[16]) begin
            bank_lo[addr[15:0]] <= wdata;
        end
        if (we && addr[16]) begin
            bank_hi[addr[15:0]] <= wdata;
        end
        // Both banks read every cycle
        lo_q  <= bank_lo[addr[15:0]];
        hi_q  <= bank_hi[addr[15:0]];
        sel_q <= addr[16];
    end

    // Swap by the registered bank bit
    assign rd.data      = sel_q ? hi_q : lo_q;
    assign rd.data_pair = sel_q ? lo_q : hi_q;

endmodule

// File: verilog/vdp_vram_arbiter.sv
// VRAM arbiter
// Display fetch has absolute priority, the host port is served in
// the first free cycle and answered with a four-phase req/ack

module vdp_vram_arbiter (
    input  logic                      CLK21M,
    input  logic                      RESET,
    input  vdp_video_pkg::fetch_req_t fetch,
    input  vdp_video_pkg::host_req_t  host_req,
    output vdp_video_pkg::host_rsp_t  host_rsp,
    output logic                      ram_we,
    output vdp_video_pkg::vram_addr_t ram_addr,
    output logic [7:0]                ram_wdata,
    input  vdp_video_pkg::vram_rd_t   ram_rd
);

    typedef enum logic [1:0] {
        IDLE    = 2'd0,
        ACCESS  = 2'd1,
        ACK     = 2'd2,
        RELEASE = 2'd3
    } arb_state_e;

    arb_state_e state;
    logic       host_slot;
    logic       ack_q;
    logic [7:0] rdata_q;

    // Host owns the RAM only while waiting and no fetch is present
    assign host_slot = (state == ACCESS) && !fetch.valid;

    assign ram_addr  = fetch.valid ? fetch.addr : host_req.addr;
    assign ram_we    = host_slot && host_req.write;
    assign ram_wdata = host_req.wdata;

    // --------------------
    // Handshake FSM
    // --------------------

    always_ff @(posedge CLK21M or posedge RESET) begin
        if (RESET) begin
            state <= IDLE;
            ack_q <= 1'b0;
        end else begin
            case (state)
                IDLE: begin
                    if (host_req.req) begin
                        state <= ACCESS;
                    end
                end
                ACCESS: begin
                    // Stall here while the display fetches
                    if (!fetch.valid) begin
                        state <= ACK;
                    end
                end
                ACK: begin
                    ack_q <= 1'b1;
                    state <= RELEASE;
                end
                default: begin
                    // Hold ack until the host lets go
                    if (!host_req.req) begin
                        ack_q <= 1'b0;
                        state <= IDLE;
                    end
                end
            endcase
        end
    end

    // Read data of the host access, separate from the display path
    always_ff @(posedge CLK21M) begin
        if (state == ACK && !host_req.write) begin
            rdata_q <= ram_rd.data;
        end
    end

    assign host_rsp = '{ack: ack_q, rdata: rdata_q};

endmodule

// File: verilog/vdp_graphic4567.sv
// Bitmap fetch for graphic modes 4 to 7
// Reads one eight-dot group ahead into a 4-entry FIFO, then turns
// the bytes into colour codes or YJK-decoded RGB per dot

module vdp_graphic4567 (
    input  logic                        CLK21M,
    input  logic                        RESET,
    input  vdp_timing_pkg::dot_timing_t timing,
    input  vdp_video_pkg::vdp_regs_t    regs,
    output vdp_video_pkg::fetch_req_t   fetch,
    input  vdp_video_pkg::vram_rd_t     rd,
    output vdp_video_pkg::pixel_t       pixel
);

    logic                      first_cyc;
    logic                      fetch_dot;
    logic                      last_grp;
    logic [5:0]                next_grp;
    logic [5:0]                scr_grp;
    logic [8:0]                next_y;
    logic [6:0]                name_base;
    logic [7:0]                fetch_y;
    logic [7:0]                local_x;
    vdp_video_pkg::vram_addr_t addr_g45;
    vdp_video_pkg::vram_addr_t addr_g67;
    logic                      fetch_valid;
    vdp_video_pkg::vram_addr_t fetch_addr;
    logic                      rd_pend;
    logic [1:0]                wr_ptr;
    vdp_video_pkg::vram_rd_t   fifo [4];
    vdp_video_pkg::vram_rd_t   pix [4];
    vdp_video_pkg::vram_rd_t   sel;
    vdp_video_pkg::vram_rd_t   grp_lo;
    vdp_video_pkg::vram_rd_t   grp_hi;
    logic [7:0]                cur_byte;
    logic [4:0]                yy;
    logic signed [5:0]         jj;
    logic signed [5:0]         kk;
    logic signed [9:0]         r_s;
    logic signed [9:0]         g_s;
    logic signed [9:0]         b_sum;
    logic [7:0]                code_w;
    logic                      yjk_w;
    logic                      active;
    logic                      out_cyc;
    logic                      pix_valid;
    logic                      pix_yjk;
    vdp_timing_pkg::dot_pos_t  pix_pos;
    logic [7:0]                pix_code;
    vdp_video_pkg::rgb_t       pix_rgb;

    // Clamp a YJK channel to 0..31, then scale to 6 bits
    function automatic logic [5:0] clamp_dbl(input logic signed [9:0] v);
        logic [5:0] res;
        if (v < 0) begin
            res = '0;
        end else if (v > 10'sd31) begin
            res = 6'd62;
        end else begin
            res = {v[4:0], 1'b0};
        end
        return res;
    endfunction

    assign first_cyc = (timing.state == vdp_timing_pkg::DS_LATCH) && (timing.eight == 3'd0);
    // Dots 0-3 of a group fetch, one byte (pair) each
    assign fetch_dot = !timing.eight[2];
    assign out_cyc   = (timing.state == vdp_timing_pkg::DS_OUT);
    assign active    = (timing.pos.x < 9'(vdp_timing_pkg::H_ACTIVE)) &&
                       (timing.pos.y < 9'(vdp_timing_pkg::V_ACTIVE));

    // --------------------
    // Fetch address
    // --------------------

    // Short last group of the line prefetches dot 0 of the next line
    assign last_grp = (timing.pos.x[8:3] == 6'((vdp_timing_pkg::H_TOTAL - 1) >> 3));
    assign next_grp = last_grp ? 6'd0 : timing.pos.x[8:3] + 6'd1;
    assign scr_grp  = next_grp + regs.h_scroll[8:3];
    assign next_y   = !last_grp ? timing.pos.y :
                      (timing.pos.y == 9'(vdp_timing_pkg::V_TOTAL - 1)) ? 9'd0 :
                      timing.pos.y + 9'd1;

    always_ff @(posedge CLK21M or posedge RESET) begin
        if (RESET) begin
            name_base <= '0;
            fetch_y   <= '0;
            local_x   <= '0;
        end else if (first_cyc) begin
            name_base <= regs.name_base;
            fetch_y   <= next_y[7:0];
            local_x   <= {scr_grp[4:0], 3'b000};
        end else if (timing.state == vdp_timing_pkg::DS_SHIFT && fetch_dot) begin
            local_x   <= local_x + 8'd2;
        end
    end

    // Modes 4/5 two dots per byte, modes 6/7 linear with bit 0 moved to the top
    assign addr_g45 = {name_base[6:5], name_base[4:0] & fetch_y[7:3], fetch_y[2:0],
                       local_x[7:1]};
    assign addr_g67 = {local_x[0], name_base[5], name_base[4:0] & fetch_y[7:3],
                       fetch_y[2:0], local_x[7:1]};

    // Request valid during DS_ADDR only
    always_ff @(posedge CLK21M or posedge RESET) begin
        if (RESET) begin
            fetch_valid <= 1'b0;
            rd_pend     <= 1'b0;
            wr_ptr      <= '0;
        end else begin
            fetch_valid <= (timing.state == vdp_timing_pkg::DS_SHIFT) && fetch_dot;
            rd_pend     <= fetch_valid;
            if (first_cyc) begin
                wr_ptr <= '0;
            end else if (rd_pend) begin
                wr_ptr <= wr_ptr + 2'd1;
            end
        end
    end

    always_ff @(posedge CLK21M) begin
        if (timing.state == vdp_timing_pkg::DS_SHIFT) begin
            if (regs.mode == vdp_video_pkg::GRAPHIC4 || regs.mode == vdp_video_pkg::GRAPHIC5) begin
                fetch_addr <= addr_g45;
            end else begin
                fetch_addr <= addr_g67;
            end
        end
        // Read data lands one cycle after the request
        if (rd_pend) begin
            fifo[wr_ptr] <= rd;
        end
        // Whole group moves to the shifter at group start
        if (first_cyc) begin
            pix <= fifo;
        end
    end

    assign fetch = '{valid: fetch_valid, addr: fetch_addr};

    // --------------------
    // Pixel select and YJK
    // --------------------

    always_comb begin
        sel      = pix[timing.eight[2:1]];
        grp_lo   = pix[{timing.eight[2], 1'b0}];
        grp_hi   = pix[{timing.eight[2], 1'b1}];
        cur_byte = timing.eight[0] ? sel.data_pair : sel.data;

        // YJK group is four consecutive bytes, two entries of the FIFO
        yy    = cur_byte[7:3];
        kk    = {grp_lo.data_pair[2:0], grp_lo.data[2:0]};
        jj    = {grp_hi.data_pair[2:0], grp_hi.data[2:0]};
        r_s   = $signed({5'b0, yy}) + jj;
        g_s   = $signed({5'b0, yy}) + kk;
        b_sum = 10'sd5 * $signed({5'b0, yy}) - 10'sd2 * jj - kk + 10'sd2;

        yjk_w = 1'b0;
        case (regs.mode)
            vdp_video_pkg::GRAPHIC4, vdp_video_pkg::GRAPHIC5: begin
                // Even dot high nibble, odd dot low nibble
                code_w = {4'h0, timing.eight[0] ? sel.data[3:0] : sel.data[7:4]};
            end
            vdp_video_pkg::GRAPHIC6: begin
                // Two half-dot colours, left one in the high nibble
                code_w = cur_byte;
            end
            default: begin
                if (regs.yjk && regs.yae && cur_byte[3]) begin
                    // Palette dot inside a YJK picture
                    code_w = {4'h0, cur_byte[7:4]};
                end else begin
                    code_w = cur_byte;
                    yjk_w  = regs.yjk;
                end
            end
        endcase
    end

    // --------------------
    // Output register
    // --------------------

    always_ff @(posedge CLK21M or posedge RESET) begin
        if (RESET) begin
            pix_valid <= 1'b0;
            pix_yjk   <= 1'b0;
        end else begin
            // One strobe per visible dot
            pix_valid <= out_cyc && active;
            if (out_cyc) begin
                pix_yjk <= yjk_w;
            end
        end
    end

    always_ff @(posedge CLK21M) begin
        if (out_cyc) begin
            pix_pos   <= timing.pos;
            pix_code  <= code_w;
            pix_rgb.r <= clamp_dbl(r_s);
            pix_rgb.g <= clamp_dbl(g_s);
            pix_rgb.b <= clamp_dbl(b_sum >>> 2);
        end
    end

    assign pixel = '{
        valid:  pix_valid,
        pos:    pix_pos,
        code:   pix_code,
        rgb:    pix_rgb,
        yjk_en: pix_yjk
    };

endmodule

// File: verilog/vdp_top.sv
// Bitmap display path top
// Dot timer, bitmap fetch, VRAM arbiter and the 128 KB video RAM

module vdp_top (
    input  logic                     CLK21M,
    input  logic                     RESET,
    input  vdp_video_pkg::vdp_regs_t regs,
    input  vdp_video_pkg::host_req_t host_req,
    output vdp_video_pkg::host_rsp_t host_rsp,
    output vdp_video_pkg::pixel_t    pixel
);

    vdp_timing_pkg::dot_timing_t timing;
    vdp_video_pkg::fetch_req_t   fetch;
    vdp_video_pkg::vram_rd_t     ram_rd;
    vdp_video_pkg::vram_addr_t   ram_addr;
    logic                        ram_we;
    logic [7:0]                  ram_wdata;

    vdp_dot_timer u_timer (
        .CLK21M (CLK21M),
        .RESET  (RESET),
        .timing (timing)
    );

    vdp_graphic4567 u_graphic (
        .CLK21M (CLK21M),
        .RESET  (RESET),
        .timing (timing),
        .regs   (regs),
        .fetch  (fetch),
        .rd     (ram_rd),
        .pixel  (pixel)
    );

    // Display and host share the single RAM port
    vdp_vram_arbiter u_arbiter (
        .CLK21M    (CLK21M),
        .RESET     (RESET),
        .fetch     (fetch),
        .host_req  (host_req),
        .host_rsp  (host_rsp),
        .ram_we    (ram_we),
        .ram_addr  (ram_addr),
        .ram_wdata (ram_wdata),
        .ram_rd    (ram_rd)
    );

    vdp_vram u_vram (
        .CLK21M (CLK21M),
        .we     (ram_we),
        .addr   (ram_addr),
        .wdata  (ram_wdata),
        .rd     (ram_rd)
    );

endmodule

// File: sim/tb_vdp.sv
// Testbench for the bitmap display path
// Runs the command list of the tests file: host VRAM traffic over
// the req/ack port, register settings and per-dot pixel checks

module tb_vdp;

    timeunit 1ns;
    timeprecision 100ps;

    // Host access ends within a few dots, a pixel within two frames
    localparam int ACK_TIMEOUT   = 100;
    localparam int FRAME_TIMEOUT = 800000;

    logic                     CLK21M;
    logic                     RESET;
    vdp_video_pkg::vdp_regs_t regs;
    vdp_video_pkg::host_req_t host_req;
    vdp_video_pkg::host_rsp_t host_rsp;
    vdp_video_pkg::pixel_t    pixel;

    // Copy of every byte the host wrote
    logic [7:0] shadow [131072];
    int         seed;

    vdp_top dut (
        .CLK21M   (CLK21M),
        .RESET    (RESET),
        .regs     (regs),
        .host_req (host_req),
        .host_rsp (host_rsp),
        .pixel    (pixel)
    );

    always #2 CLK21M = ~CLK21M;

    task automatic abort_run;
        $display("TEST FAIL");
        $fatal(1);
    endtask

    // --------------------
    // Compare tasks
    // --------------------

    task automatic check_byte(input vdp_video_pkg::vram_addr_t addr, input logic [7:0] got,
                              input logic [7:0] exp);
        if (got !== exp) begin
            $display("ERR %0t: VRAM %05h read %02h, expected %02h", $time, addr, got, exp);
            abort_run();
        end
    endtask

    task automatic check_code(input vdp_timing_pkg::dot_pos_t pos, input logic [7:0] got,
                              input logic [7:0] exp);
        if (got !== exp) begin
            $display("ERR %0t: code at (%0d,%0d) is %02h, expected %02h",
                     $time, pos.x, pos.y, got, exp);
            abort_run();
        end
    endtask

    // RGB only means something with yjk_en high
    task automatic check_rgb(input vdp_timing_pkg::dot_pos_t pos, input vdp_video_pkg::rgb_t got,
                             input logic got_en, input vdp_video_pkg::rgb_t exp,
                             input logic exp_en);
        if (got_en !== exp_en || (exp_en && got !== exp)) begin
            $display("ERR %0t: rgb (%0d,%0d) is %02h %02h %02h/%0b, expected %02h %02h %02h/%0b",
                     $time, pos.x, pos.y, got.r, got.g, got.b, got_en,
                     exp.r, exp.g, exp.b, exp_en);
            abort_run();
        end
    endtask

    // --------------------
    // Host port and waits
    // --------------------

    // One access over the four-phase req/ack
    task automatic host_access(input logic wr, input vdp_video_pkg::vram_addr_t addr,
                               input logic [7:0] wdata, output logic [7:0] rdata);
        int cnt;
        cnt = 0;
        @(posedge CLK21M);
        host_req <= '{req: 1'b1, write: wr, addr: addr, wdata: wdata};
        @(negedge CLK21M);
        while (host_rsp.ack !== 1'b1) begin
            cnt++;
            if (cnt > ACK_TIMEOUT) begin
                $display("host ack never rose, address %05h", addr);
                abort_run();
            end
            @(negedge CLK21M);
        end
        rdata = host_rsp.rdata;
        @(posedge CLK21M);
        host_req <= '{req: 1'b0, write: wr, addr: addr, wdata: wdata};
        cnt = 0;
        @(negedge CLK21M);
        while (host_rsp.ack !== 1'b0) begin
            cnt++;
            if (cnt > ACK_TIMEOUT) begin
                $display("host ack never fell, address %05h", addr);
                abort_run();
            end
            @(negedge CLK21M);
        end
    endtask

    // Next pixel drawn for dot (x,y)
    task automatic wait_pixel(input logic [8:0] x, input logic [8:0] y,
                              output vdp_video_pkg::pixel_t got);
        int cnt;
        cnt = 0;
        @(negedge CLK21M);
        while (!(pixel.valid === 1'b1 && pixel.pos.x == x && pixel.pos.y == y)) begin
            cnt++;
            if (cnt > FRAME_TIMEOUT) begin
                $display("pixel at (%0d,%0d) never came out", x, y);
                abort_run();
            end
            @(negedge CLK21M);
        end
        got = pixel;
    endtask

    // Every fetch after the last visible dot sees the new registers
    task automatic wait_frame_end;
        vdp_video_pkg::pixel_t last;
        wait_pixel(9'(vdp_timing_pkg::H_ACTIVE - 1), 9'(vdp_timing_pkg::V_ACTIVE - 1), last);
    endtask

    task automatic bad_line(input string line);
        $display("malformed line in tests file: %s", line);
        abort_run();
    endtask

    // --------------------
    // Command interpreter
    // --------------------

    task automatic run_command(input string line);
        int                        n;
        logic [31:0]               a;
        logic [31:0]               b;
        logic [31:0]               c;
        logic [31:0]               d;
        logic [31:0]               e;
        logic [31:0]               f;
        logic [7:0]                kind;
        logic [7:0]                rdata;
        logic [7:0]                fill;
        vdp_video_pkg::vram_addr_t addr;
        vdp_video_pkg::pixel_t     got;
        vdp_video_pkg::rgb_t       exp_rgb;
        case (line.getc(0))
            "W": begin
                n = $sscanf(line, "W %h %h", a, b);
                if (n != 2) bad_line(line);
                host_access(1'b1, a[16:0], b[7:0], rdata);
                shadow[a[16:0]] = b[7:0];
            end
            "R": begin
                n = $sscanf(line, "R %h %h", a, b);
                if (n != 2) bad_line(line);
                host_access(1'b0, a[16:0], 8'h00, rdata);
                check_byte(a[16:0], rdata, b[7:0]);
            end
            "F": begin
                // Random bytes go to the shadow copy as well
                n = $sscanf(line, "F %h %d", a, b);
                if (n != 2) bad_line(line);
                for (int i = 0; i < int'(b); i++) begin
                    addr = 17'(a + i);
                    fill = 8'($random(seed));
                    host_access(1'b1, addr, fill, rdata);
                    shadow[addr] = fill;
                end
            end
            "C": begin
                n = $sscanf(line, "C %h %d", a, b);
                if (n != 2) bad_line(line);
                for (int i = 0; i < int'(b); i++) begin
                    addr = 17'(a + i);
                    host_access(1'b0, addr, 8'h00, rdata);
                    check_byte(addr, rdata, shadow[addr]);
                end
            end
            "M": begin
                n = $sscanf(line, "M %h %h %h %h %h", a, b, c, d, e);
                if (n != 5) bad_line(line);
                @(posedge CLK21M);
                regs <= '{mode: vdp_video_pkg::screen_mode_e'(a[1:0]), name_base: b[6:0],
                          h_scroll: c[8:0], yjk: d[0], yae: e[0]};
                wait_frame_end();
            end
            "P": begin
                n = $sscanf(line, "P %d %d %c", a, b, kind);
                if (n != 3) bad_line(line);
                wait_pixel(a[8:0], b[8:0], got);
                if (kind == "C") begin
                    n = $sscanf(line, "P %d %d C %h", a, b, c);
                    if (n != 3) bad_line(line);
                    check_code(got.pos, got.code, c[7:0]);
                end else begin
                    n = $sscanf(line, "P %d %d Y %h %h %h %h", a, b, c, d, e, f);
                    if (n != 6) bad_line(line);
                    exp_rgb = '{r: c[5:0], g: d[5:0], b: e[5:0]};
                    check_rgb(got.pos, got.rgb, got.yjk_en, exp_rgb, f[0]);
                end
            end
            default: begin
                // Comment or blank line
            end
        endcase
    endtask

    initial begin
        int    fd;
        int    n;
        string line;
        CLK21M   = 1'b0;
        RESET    = 1'b1;
        regs     = '{mode: vdp_video_pkg::GRAPHIC4, name_base: 7'h1F, h_scroll: 9'd0,
                     yjk: 1'b0, yae: 1'b0};
        host_req = '0;
        seed     = 79482;
        repeat (10) @(posedge CLK21M);
        RESET <= 1'b0;

        fd = $fopen("sim/vdp_tests.txt", "r");
        if (fd == 0) begin
            $display("cannot open sim/vdp_tests.txt");
            abort_run();
        end
        while (!$feof(fd)) begin
            line = "";
            n = $fgets(line, fd);
            if (n > 0) begin
                run_command(line);
            end
        end
        $fclose(fd);

        $display("TEST PASS");
        $finish;
    end

endmodule

// File: sim/vdp_tests.txt
# W addr data | R addr exp | F addr count | C addr count | M mode base scroll yjk yae
# P x y C code | P x y Y r g b yjk_en   (addresses and values hex, x y count decimal)
# Host writes, each read back at once
W 00285 A7
R 00285 A7
W 03264 3C
R 03264 3C
W 00A20 53
W 10A20 67
W 00A21 A1
W 10A21 F8
W 14B64 5E
R 10A20 67
R 10A21 F8
R 14B64 5E
# Random filler outside the displayed area
F 0C000 24
C 0C000 24
F 1C100 12
C 1C100 12
# GRAPHIC4, nibbles of y*128 + x/2
M 0 1F 000 0 0
P 10 5 C 0A
P 11 5 C 07
P 200 100 C 03
P 201 100 C 0C
# GRAPHIC4 scrolled by 24 dots
M 0 1F 018 0 0
P 242 5 C 0A
P 243 5 C 07
P 176 100 C 03
P 177 100 C 0C
# GRAPHIC7, full byte of the interleaved address
M 3 1F 000 0 0
P 64 20 C 53
P 65 20 C 67
P 66 20 C A1
P 67 20 C F8
P 201 150 C 5E
# GRAPHIC7 YJK, group J=1 K=-5
M 3 1F 000 1 0
P 64 20 Y 16 0A 1A 1
P 65 20 Y 1A 0E 20 1
P 66 20 Y 2A 1E 34 1
P 67 20 Y 3E 34 3E 1
# YJK with YAE, last byte has bit 3 set
M 3 1F 000 1 1
P 64 20 Y 16 0A 1A 1
P 65 20 Y 1A 0E 20 1
P 66 20 Y 2A 1E 34 1
P 67 20 C 0F
P 67 20 Y 00 00 00 0

// File: sim.f
verilog/vdp_timing_pkg.sv
verilog/vdp_video_pkg.sv
verilog/vdp_dot_timer.sv
verilog/vdp_vram.sv
verilog/vdp_vram_arbiter.sv
verilog/vdp_graphic4567.sv
verilog/vdp_top.sv
sim/tb_vdp.sv

// File: Makefile
VERILATOR  ?= verilator
TOP        := tb_vdp
FILELIST   := sim.f
OBJ_DIR    := obj_dir
FLAGS      := --binary --timing -j 0 -Wno-fatal --Mdir $(OBJ_DIR)
LINT_FLAGS := --lint-only --timing -Wall

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

# Pass only if the testbench printed its pass line
run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "TEST PASS"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
